//--- wb_biu_top.f
hw/wb_biu_pkg.sv
hw/wb_biu_responder.sv
hw/biu_sram_bank.sv
hw/biu_cfg_regs.sv
hw/biu_sram_ctrl.sv
hw/wb_biu_top.sv
dv/wb_biu_checker.sv
dv/wb_biu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the Wishbone BIU testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module wb_biu_tb -f wb_biu_top.f -o wb_biu_sim

# The simulation may stop with an error status, the log decides
./obj_dir/wb_biu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
    echo "Simulation result: PASS"
    exit 0
fi
echo "Simulation result: FAIL, see sim.log"
exit 1

//--- dv/wb_biu_tb.sv
// Testbench for the Wishbone BIU subsystem
// Clock, reset, LFSR stimulus and Wishbone bus tasks
// Reference model with shadow SRAM, CTRL and beat count
// Read compare process and hang watchdog
`timescale 1ns/100ps
`default_nettype none

module wb_biu_tb;
    import wb_biu_pkg::*;

    localparam logic [31:0] BASE_ADDR  = 32'h0;
    localparam int          MEM_WORDS  = 64;
    localparam logic [31:0] CFG_ADDR   = 32'h1000;
    localparam logic [31:0] MEM_BYTES  = MEM_WORDS * 4;
    localparam int          RST_CYCLES = 10;
    // Beats issued below, random bursts at their longest
    localparam int          PLANNED_BEATS = 2 * MEM_WORDS + 2 * 2 * 17 + 16 * 3 + 7 + 11 + 3 + 2;
    localparam int          ACK_LIMIT     = 16;
    localparam int          CLK_PERIOD    = 20;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_cti;
    logic [1:0]  wb_bte;
    logic [3:0]  wb_sel;
    logic [31:0] wb_addr;
    logic [31:0] wb_data;
    logic        wb_ack;
    logic [31:0] wb_rdata;

    // Reference model state
    logic [31:0] shadow_mem [MEM_WORDS];
    logic [2:0]  shadow_ws;
    logic        shadow_wp;
    logic [31:0] shadow_beats;

    logic [31:0] exp_q [$];
    logic [31:0] cmp_data;
    logic [15:0] lfsr_q = 16'd38604;
    int          err_cnt;
    bit          run_done;

    wb_biu_top #(
        .OPTN_BASE_ADDR (BASE_ADDR),
        .OPTN_MEM_WORDS (MEM_WORDS),
        .OPTN_CFG_ADDR  (CFG_ADDR)
    ) u_wb_biu_top (
        .i_wb_clk  (clk),
        .i_rst_n   (rst_n),
        .i_wb_cyc  (wb_cyc),
        .i_wb_stb  (wb_stb),
        .i_wb_we   (wb_we),
        .i_wb_cti  (wb_cti),
        .i_wb_bte  (wb_bte),
        .i_wb_sel  (wb_sel),
        .i_wb_addr (wb_addr),
        .i_wb_data (wb_data),
        .o_wb_ack  (wb_ack),
        .o_wb_data (wb_rdata)
    );

    // Protocol assertions, names resolve inside the top level
    bind wb_biu_top wb_biu_checker u_checker (
        .i_wb_clk (i_wb_clk),
        .i_rst_n  (i_rst_n),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_cti (i_wb_cti),
        .i_wb_ack (o_wb_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_error(input string line);
        err_cnt++;
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < n; b++) begin
            value  = {value[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return value;
    endfunction

    // Updates the model for one beat, returns expected read data
    function automatic logic [31:0] ref_access(input logic we, input logic [31:0] addr,
                                               input logic [3:0] sel, input logic [31:0] wdata);
        logic [31:0] rdata;
        int          word;
        rdata = '0;
        if (addr < MEM_BYTES) begin
            word  = int'(addr >> 2);
            rdata = shadow_mem[word];
            // Protected writes complete but change nothing
            if (we && !shadow_wp) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (sel[lane]) begin
                        shadow_mem[word][lane*8 +: 8] = wdata[lane*8 +: 8];
                    end
                end
            end
            shadow_beats++;
        end else if (addr == CFG_ADDR) begin
            rdata = {23'd0, shadow_wp, 5'd0, shadow_ws};
            if (we && sel[0]) begin
                shadow_ws = wdata[2:0];
            end
            if (we && sel[1]) begin
                shadow_wp = wdata[8];
            end
        end else if (addr == CFG_ADDR + 32'd4) begin
            // BEATS is read only
            rdata = shadow_beats;
        end
        return rdata;
    endfunction

    // Cycles from beat drive to ACK, 0 for a streamed burst beat
    function automatic int expect_latency(input logic [31:0] addr, input bit streamed);
        if (addr >= MEM_BYTES) begin
            return 1;
        end
        if (streamed && shadow_ws == 3'd0) begin
            return 0;
        end
        return 1 + int'(shadow_ws);
    endfunction

    task automatic drive_idle();
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_cti  = WB_CTI_CLASSIC;
        wb_sel  = 4'h0;
        wb_addr = 32'h0;
        wb_data = 32'h0;
    endtask

    // ACK sampled at the falling edge, well clear of the drive point
    task automatic wait_ack(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!wb_ack) begin
            cycles++;
            assert (cycles < ACK_LIMIT)
                else stop_on_error("Beat was never acknowledged by the DUT");
            @(negedge clk);
        end
    endtask

    // Classic single beat or linear incrementing burst
    task automatic bus_beats(input logic we, input logic [31:0] addr0, input int len,
                             input logic [3:0] sel, input bit burst,
                             input bit fixed_wdata = 1'b0,
                             input logic [31:0] wdata_val = 32'h0);
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_data;
        int          exp_lat;
        int          lat;
        @(posedge clk);
        #2;
        for (int i = 0; i < len; i++) begin
            addr = addr0 + 32'(i * 4);
            if (!we) begin
                wdata = 32'd0;
            end else if (fixed_wdata) begin
                wdata = wdata_val;
            end else begin
                wdata = draw_bits(32);
            end
            exp_lat  = expect_latency(addr, burst && (i > 0));
            exp_data = ref_access(we, addr, sel, wdata);
            if (!we) begin
                exp_q.push_back(exp_data);
            end
            wb_cyc  = 1'b1;
            wb_stb  = 1'b1;
            wb_we   = we;
            wb_cti  = !burst ? WB_CTI_CLASSIC : ((i == len - 1) ? WB_CTI_EOB : WB_CTI_INCR);
            wb_sel  = sel;
            wb_addr = addr;
            wb_data = wdata;
            wait_ack(lat);
            assert (lat == exp_lat)
                else stop_on_error($sformatf("FAIL t=%0t o_wb_ack latency got %0d expected %0d",
                                             $time, lat, exp_lat));
            @(posedge clk);
            #2;
        end
        drive_idle();
    endtask

    // Every acknowledged read against the model
    always @(negedge clk) begin
        if (rst_n && wb_ack && !wb_we) begin
            assert (exp_q.size() > 0)
                else stop_on_error("Read acknowledged with no expected data pending");
            if (exp_q.size() > 0) begin
                cmp_data = exp_q.pop_front();
                assert (wb_rdata === cmp_data)
                    else stop_on_error($sformatf(
                        "FAIL t=%0t o_wb_data got 0x%08h expected 0x%08h",
                        $time, wb_rdata, cmp_data));
            end
        end
    end

    // Watchdog sized from the planned beats plus reset
    initial begin
        #((PLANNED_BEATS * 200 + RST_CYCLES) * CLK_PERIOD);
        err_cnt++;
        $display("Watchdog expired, the DUT or the testbench hung");
        $display("Test failed");
        $fatal(1, "Simulation stopped by watchdog");
    end

    // Catches runs stopped by a checker assertion
    final begin
        if (!run_done && err_cnt == 0) begin
            $display("Test failed");
        end
    end

    initial begin
        int len;
        int start;
        int word;
        clk          = 1'b0;
        rst_n        = 1'b0;
        wb_bte       = 2'b00;
        err_cnt      = 0;
        run_done     = 1'b0;
        shadow_ws    = 3'd0;
        shadow_wp    = 1'b0;
        shadow_beats = '0;
        drive_idle();
        repeat (2) @(posedge clk);
        #2;
        // Beat pending during reset, ACK has to stay low
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        repeat (RST_CYCLES - 3) @(posedge clk);
        #2;
        drive_idle();
        @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Fill and read back the whole SRAM with zero wait bursts
        for (int b = 0; b < MEM_WORDS / 16; b++) begin
            bus_beats(1'b1, BASE_ADDR + 32'(b * 64), 16, 4'hF, 1'b1);
        end
        for (int b = 0; b < MEM_WORDS / 16; b++) begin
            bus_beats(1'b0, BASE_ADDR + 32'(b * 64), 16, 4'hF, 1'b1);
        end

        // Random length bursts at random start words
        for (int r = 0; r < 2; r++) begin
            len   = 2 + int'(draw_bits(4));
            start = int'(draw_bits(6));
            if (start + len > MEM_WORDS) begin
                start = MEM_WORDS - len;
            end
            bus_beats(1'b1, BASE_ADDR + 32'(start * 4), len, 4'hF, 1'b1);
            bus_beats(1'b0, BASE_ADDR + 32'(start * 4), len, 4'hF, 1'b1);
        end

        // Classic writes with random lane masks, then reads
        for (int r = 0; r < 16; r++) begin
            word = int'(draw_bits(6));
            bus_beats(1'b1, BASE_ADDR + 32'(word * 4), 1, 4'(draw_bits(4)), 1'b0);
            bus_beats(1'b0, BASE_ADDR + 32'(word * 4), 1, 4'hF, 1'b0);
            bus_beats(1'b0, BASE_ADDR + 32'(draw_bits(6) * 4), 1, 4'hF, 1'b0);
        end

        // Three wait states on classic and burst beats
        bus_beats(1'b1, CFG_ADDR, 1, 4'h1, 1'b0, 1'b1, 32'h0000_0003);
        bus_beats(1'b0, CFG_ADDR, 1, 4'hF, 1'b0);
        bus_beats(1'b1, BASE_ADDR + 32'h10, 1, 4'hF, 1'b0);
        bus_beats(1'b0, BASE_ADDR + 32'h10, 1, 4'hF, 1'b0);
        bus_beats(1'b0, BASE_ADDR + 32'h20, 3, 4'hF, 1'b1);

        // Write protect set, writes ignored, then cleared
        bus_beats(1'b1, CFG_ADDR, 1, 4'h2, 1'b0, 1'b1, 32'h0000_0100);
        bus_beats(1'b0, CFG_ADDR, 1, 4'hF, 1'b0);
        bus_beats(1'b1, BASE_ADDR + 32'h40, 2, 4'hF, 1'b1);
        bus_beats(1'b0, BASE_ADDR + 32'h40, 2, 4'hF, 1'b1);
        @(posedge clk);
        #2;
        bus_beats(1'b1, CFG_ADDR, 1, 4'h3, 1'b0, 1'b1, 32'h0000_0000);
        bus_beats(1'b1, BASE_ADDR + 32'h40, 2, 4'hF, 1'b1);
        bus_beats(1'b0, BASE_ADDR + 32'h40, 2, 4'hF, 1'b1);

        // BEATS count, then a write that must not change it
        bus_beats(1'b0, CFG_ADDR + 32'd4, 1, 4'hF, 1'b0);
        bus_beats(1'b1, CFG_ADDR + 32'd4, 1, 4'hF, 1'b0);
        bus_beats(1'b0, CFG_ADDR + 32'd4, 1, 4'hF, 1'b0);

        // Unmapped reads answer zero after one cycle
        bus_beats(1'b0, 32'h0000_2000, 1, 4'hF, 1'b0);
        bus_beats(1'b0, CFG_ADDR + 32'd8, 1, 4'hF, 1'b0);

        repeat (2) @(posedge clk);
        assert (exp_q.size() == 0)
            else stop_on_error("Expected reads left over without an acknowledge");
        run_done = 1'b1;
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/wb_biu_checker.sv
// Wishbone protocol checker for the BIU subsystem
// Concurrent assertions only, attached to the top level by bind
`timescale 1ns/100ps
`default_nettype none

module wb_biu_checker (
    input logic                                i_wb_clk,
    input logic                                i_rst_n,
    input logic                                i_wb_cyc,
    input logic                                i_wb_stb,
    input logic [wb_biu_pkg::WB_CTI_WIDTH-1:0] i_wb_cti,
    input logic                                i_wb_ack
);
    import wb_biu_pkg::*;

    // Classic beat pending and not yet answered
    logic classic_wait;

    assign classic_wait = i_wb_cyc && i_wb_stb && (i_wb_cti == WB_CTI_CLASSIC) && !i_wb_ack;

    // ACK only inside a pending beat
    ack_in_beat: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
        i_wb_ack |-> (i_wb_cyc && i_wb_stb))
        else $error("ACK seen without CYC and STB");

    ack_in_reset: assert property (@(posedge i_wb_clk)
        !i_rst_n |-> !i_wb_ack)
        else $error("ACK seen during reset");

    // Nine waiting samples in a row means no ACK within 8 cycles
    classic_ack_bound: assert property (@(posedge i_wb_clk) disable iff (!i_rst_n)
        !(classic_wait && $past(classic_wait, 1) && $past(classic_wait, 2) &&
          $past(classic_wait, 3) && $past(classic_wait, 4) && $past(classic_wait, 5) &&
          $past(classic_wait, 6) && $past(classic_wait, 7) && $past(classic_wait, 8)))
        else $error("Classic beat not acknowledged within 8 cycles");

endmodule

`default_nettype wire

//--- hw/wb_biu_top.sv
// Wishbone BIU subsystem top level
// Responder, config block, SRAM controller and SRAM bank
`timescale 1ns/100ps
`default_nettype none

module wb_biu_top #(
    parameter logic [wb_biu_pkg::WB_ADDR_WIDTH-1:0] OPTN_BASE_ADDR = 32'h0,
    parameter int                                   OPTN_MEM_WORDS = 64,
    parameter logic [wb_biu_pkg::WB_ADDR_WIDTH-1:0] OPTN_CFG_ADDR  = 32'h1000
) (
    input  logic                                 i_wb_clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_wb_cyc,
    input  logic                                 i_wb_stb,
    input  logic                                 i_wb_we,
    input  logic [wb_biu_pkg::WB_CTI_WIDTH-1:0]  i_wb_cti,
    input  logic [wb_biu_pkg::WB_BTE_WIDTH-1:0]  i_wb_bte,
    input  logic [wb_biu_pkg::WB_SEL_WIDTH-1:0]  i_wb_sel,
    input  logic [wb_biu_pkg::WB_ADDR_WIDTH-1:0] i_wb_addr,
    input  logic [wb_biu_pkg::WB_DATA_WIDTH-1:0] i_wb_data,
    output logic                                 o_wb_ack,
    output logic [wb_biu_pkg::WB_DATA_WIDTH-1:0] o_wb_data
);
    import wb_biu_pkg::*;

    // Responder to targets
    biu_req_t sram_req;
    biu_req_t cfg_req;
    biu_rsp_t sram_rsp;
    biu_rsp_t cfg_rsp;

    // Config steering and beat feedback
    cfg_ctrl_t sram_ctrl;
    logic      sram_beat;

    // Memory port
    logic                     mem_en;
    logic [WB_SEL_WIDTH-1:0]  mem_we;
    logic [WB_WORD_WIDTH-1:0] mem_addr;
    logic [WB_DATA_WIDTH-1:0] mem_wdata;
    logic [WB_DATA_WIDTH-1:0] mem_rd_data;

    wb_biu_responder #(
        .OPTN_BASE_ADDR (OPTN_BASE_ADDR),
        .OPTN_MEM_WORDS (OPTN_MEM_WORDS),
        .OPTN_CFG_ADDR  (OPTN_CFG_ADDR)
    ) u_responder (
        .i_wb_clk   (i_wb_clk),
        .i_rst_n    (i_rst_n),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_cti   (i_wb_cti),
        .i_wb_bte   (i_wb_bte),
        .i_wb_sel   (i_wb_sel),
        .i_wb_addr  (i_wb_addr),
        .i_wb_data  (i_wb_data),
        .i_sram_rsp (sram_rsp),
        .i_cfg_rsp  (cfg_rsp),
        .o_wb_ack   (o_wb_ack),
        .o_wb_data  (o_wb_data),
        .o_sram_req (sram_req),
        .o_cfg_req  (cfg_req)
    );

    biu_cfg_regs u_cfg_regs (
        .i_wb_clk (i_wb_clk),
        .i_rst_n  (i_rst_n),
        .i_req    (cfg_req),
        .i_beat   (sram_beat),
        .o_rsp    (cfg_rsp),
        .o_ctrl   (sram_ctrl)
    );

    biu_sram_ctrl u_sram_ctrl (
        .i_wb_clk    (i_wb_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (sram_req),
        .i_ctrl      (sram_ctrl),
        .i_rd_data   (mem_rd_data),
        .o_rsp       (sram_rsp),
        .o_beat      (sram_beat),
        .o_mem_en    (mem_en),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata)
    );

    biu_sram_bank #(
        .OPTN_MEM_WORDS (OPTN_MEM_WORDS)
    ) u_sram_bank (
        .i_wb_clk    (i_wb_clk),
        .i_mem_en    (mem_en),
        .i_mem_we    (mem_we),
        .i_mem_addr  (mem_addr),
        .i_mem_wdata (mem_wdata),
        .o_rd_data   (mem_rd_data)
    );

endmodule

`default_nettype wire

//--- hw/biu_sram_ctrl.sv
// SRAM beat sequencer
// Programmable wait states before each beat
// Back-to-back streaming for linear bursts without wait states
// Write lane masking under write protect, beat pulse to config block
`timescale 1ns/100ps
`default_nettype none

module biu_sram_ctrl (
    input  logic                                 i_wb_clk,
    input  logic                                 i_rst_n,
    input  wb_biu_pkg::biu_req_t                 i_req,
    input  wb_biu_pkg::cfg_ctrl_t                i_ctrl,
    input  logic [wb_biu_pkg::WB_DATA_WIDTH-1:0] i_rd_data,
    output wb_biu_pkg::biu_rsp_t                 o_rsp,
    output logic                                 o_beat,
    output logic                                 o_mem_en,
    output logic [wb_biu_pkg::WB_SEL_WIDTH-1:0]  o_mem_we,
    output logic [wb_biu_pkg::WB_WORD_WIDTH-1:0] o_mem_addr,
    output logic [wb_biu_pkg::WB_DATA_WIDTH-1:0] o_mem_wdata
);
    import wb_biu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_ACCESS,
        ST_STREAM
    } state_t;

    state_t     state_q;
    state_t     state_d;
    logic [2:0] wait_cnt_q;
    logic [2:0] wait_cnt_d;
    logic       no_wait;
    logic       beat_done;
    logic       start_access;
    logic       stream_next;
    logic       write_commit;

    assign no_wait = (i_ctrl.wait_states == 3'd0);

    // ACCESS and STREAM are the acknowledge cycles
    assign beat_done = i_req.en && ((state_q == ST_ACCESS) || (state_q == ST_STREAM));

    // Edge where done gets set for a fresh beat
    assign start_access = i_req.en && (((state_q == ST_IDLE) && no_wait) ||
                                       ((state_q == ST_WAIT) && (wait_cnt_q == 3'd0)));

    // Next burst beat is acked straight after this one
    assign stream_next = beat_done & i_req.burst & ~i_req.eob & no_wait;

    // Writes commit at the end of the ack cycle, bus data is valid there
    assign write_commit = beat_done & i_req.we;

    // Reads issue one edge ahead so data lands in the ack cycle
    assign o_mem_en    = write_commit | (~i_req.we & (start_access | stream_next));
    // Protected writes still run, with no lanes enabled
    assign o_mem_we    = (write_commit && !i_ctrl.write_protect) ? i_req.sel : '0;
    // Streamed read fetches the word after the one on the bus
    assign o_mem_addr  = (stream_next && !i_req.we) ? i_req.addr + WB_WORD_WIDTH'(1)
                                                    : i_req.addr;
    assign o_mem_wdata = i_req.data;

    always_comb begin
        state_d    = state_q;
        wait_cnt_d = wait_cnt_q;
        case (state_q)
            ST_IDLE: begin
                if (i_req.en) begin
                    if (no_wait) begin
                        state_d = ST_ACCESS;
                    end else begin
                        state_d    = ST_WAIT;
                        wait_cnt_d = i_ctrl.wait_states - 3'd1;
                    end
                end
            end
            ST_WAIT: begin
                // STB dropped, give up and wait for the beat again
                if (!i_req.en) begin
                    state_d = ST_IDLE;
                end else if (wait_cnt_q == 3'd0) begin
                    state_d = ST_ACCESS;
                end else begin
                    wait_cnt_d = wait_cnt_q - 3'd1;
                end
            end
            ST_ACCESS, ST_STREAM: begin
                state_d = stream_next ? ST_STREAM : ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= ST_IDLE;
            wait_cnt_q <= 3'd0;
        end else begin
            state_q    <= state_d;
            wait_cnt_q <= wait_cnt_d;
        end
    end

    // Done and beat pulse are the same event
    assign o_rsp  = '{done: beat_done, data: i_rd_data};
    assign o_beat = beat_done;

endmodule

`default_nettype wire

//--- hw/biu_cfg_regs.sv
// Configuration and status registers
// CTRL holds wait states and write protect, byte-lane writable
// BEATS counts completed SRAM beats, read only
`timescale 1ns/100ps
`default_nettype none

module biu_cfg_regs (
    input  logic                  i_wb_clk,
    input  logic                  i_rst_n,
    input  wb_biu_pkg::biu_req_t  i_req,
    input  logic                  i_beat,
    output wb_biu_pkg::biu_rsp_t  o_rsp,
    output wb_biu_pkg::cfg_ctrl_t o_ctrl
);
    import wb_biu_pkg::*;

    logic [2:0]               wait_states_q;
    logic                     write_protect_q;
    logic [WB_DATA_WIDTH-1:0] beats_q;
    logic                     done_q;
    logic [WB_DATA_WIDTH-1:0] rd_data_q;
    logic                     accept;
    logic [WB_DATA_WIDTH-1:0] ctrl_word;

    // New beat taken only outside its own done cycle
    assign accept = i_req.en & ~done_q;

    // CTRL layout, wait states in 2:0, write protect in 8
    assign ctrl_word = {23'd0, write_protect_q, 5'd0, wait_states_q};

    always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wait_states_q   <= 3'd0;
            write_protect_q <= 1'b0;
            beats_q         <= '0;
            done_q          <= 1'b0;
        end else begin
            done_q <= accept;
            if (i_beat) begin
                beats_q <= beats_q + 1'b1;
            end
            // BEATS ignores writes
            if (accept && i_req.we && (i_req.addr == CFG_OFS_CTRL)) begin
                if (i_req.sel[0]) begin
                    wait_states_q <= i_req.data[2:0];
                end
                if (i_req.sel[1]) begin
                    write_protect_q <= i_req.data[8];
                end
            end
        end
    end

    // Read value captured with the request
    always_ff @(posedge i_wb_clk) begin
        if (accept) begin
            rd_data_q <= (i_req.addr == CFG_OFS_BEATS) ? beats_q : ctrl_word;
        end
    end

    assign o_rsp  = '{done: done_q & i_req.en, data: rd_data_q};
    assign o_ctrl = '{wait_states: wait_states_q, write_protect: write_protect_q};

endmodule

`default_nettype wire

//--- hw/biu_sram_bank.sv
// Byte-lane synchronous SRAM
// One byte array per lane, per-lane write enable
// Registered read port
`timescale 1ns/100ps
`default_nettype none

module biu_sram_bank #(
    parameter int OPTN_MEM_WORDS = 64
) (
    input  logic                                 i_wb_clk,
    input  logic                                 i_mem_en,
    input  logic [wb_biu_pkg::WB_SEL_WIDTH-1:0]  i_mem_we,
    input  logic [wb_biu_pkg::WB_WORD_WIDTH-1:0] i_mem_addr,
    input  logic [wb_biu_pkg::WB_DATA_WIDTH-1:0] i_mem_wdata,
    output logic [wb_biu_pkg::WB_DATA_WIDTH-1:0] o_rd_data
);
    import wb_biu_pkg::*;

    localparam int IDX_BITS = (OPTN_MEM_WORDS > 1) ? $clog2(OPTN_MEM_WORDS) : 1;

    logic [IDX_BITS-1:0] mem_idx;

    // Upper address bits already checked by the window decode
    assign mem_idx = i_mem_addr[IDX_BITS-1:0];

    for (genvar lane = 0; lane < WB_SEL_WIDTH; lane++) begin : g_lane
        logic [7:0] lane_mem [OPTN_MEM_WORDS];
        logic [7:0] rd_q;

        // Old contents read out on a write
        always_ff @(posedge i_wb_clk) begin
            if (i_mem_en) begin
                if (i_mem_we[lane]) begin
                    lane_mem[mem_idx] <= i_mem_wdata[lane*8 +: 8];
                end
                rd_q <= lane_mem[mem_idx];
            end
        end

        assign o_rd_data[lane*8 +: 8] = rd_q;
    end

endmodule

`default_nettype wire

//--- hw/wb_biu_responder.sv
// Wishbone B4 responder
// Address window decode for SRAM and config targets
// CTI/BTE decode into burst and end-of-burst flags
// Registered acknowledge for unmapped beats, ACK/DAT return mux
`timescale 1ns/100ps
`default_nettype none

module wb_biu_responder #(
    parameter logic [wb_biu_pkg::WB_ADDR_WIDTH-1:0] OPTN_BASE_ADDR = 32'h0,
    parameter int                                   OPTN_MEM_WORDS = 64,
    parameter logic [wb_biu_pkg::WB_ADDR_WIDTH-1:0] OPTN_CFG_ADDR  = 32'h1000
) (
    input  logic                                 i_wb_clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_wb_cyc,
    input  logic                                 i_wb_stb,
    input  logic                                 i_wb_we,
    input  logic [wb_biu_pkg::WB_CTI_WIDTH-1:0]  i_wb_cti,
    input  logic [wb_biu_pkg::WB_BTE_WIDTH-1:0]  i_wb_bte,
    input  logic [wb_biu_pkg::WB_SEL_WIDTH-1:0]  i_wb_sel,
    input  logic [wb_biu_pkg::WB_ADDR_WIDTH-1:0] i_wb_addr,
    input  logic [wb_biu_pkg::WB_DATA_WIDTH-1:0] i_wb_data,
    input  wb_biu_pkg::biu_rsp_t                 i_sram_rsp,
    input  wb_biu_pkg::biu_rsp_t                 i_cfg_rsp,
    output logic                                 o_wb_ack,
    output logic [wb_biu_pkg::WB_DATA_WIDTH-1:0] o_wb_data,
    output wb_biu_pkg::biu_req_t                 o_sram_req,
    output wb_biu_pkg::biu_req_t                 o_cfg_req
);
    import wb_biu_pkg::*;

    // SRAM size in words, at word address width
    localparam logic [WB_WORD_WIDTH-1:0] MEM_WORDS = WB_WORD_WIDTH'(OPTN_MEM_WORDS);

    logic                     wb_en;
    logic                     wb_burst;
    logic                     wb_eob;
    logic [WB_ADDR_WIDTH-1:0] sram_ofs;
    logic [WB_ADDR_WIDTH-1:0] cfg_ofs;
    logic                     sram_hit;
    logic                     cfg_hit;
    logic                     unmapped_ack_q;

    // Beat pending only with both CYC and STB
    assign wb_en = i_wb_cyc & i_wb_stb;

    // Wrap bursts fall back to single-beat handling
    assign wb_burst = (i_wb_cti == WB_CTI_INCR) && (i_wb_bte == WB_BTE_LINEAR);
    assign wb_eob   = (i_wb_cti == WB_CTI_EOB) || (i_wb_cti == WB_CTI_CLASSIC);

    // Base-relative byte offsets
    assign sram_ofs = i_wb_addr - OPTN_BASE_ADDR;
    assign cfg_ofs  = i_wb_addr - OPTN_CFG_ADDR;

    // SRAM wins if the windows ever overlap
    assign sram_hit = (i_wb_addr >= OPTN_BASE_ADDR) &&
                      (sram_ofs[WB_ADDR_WIDTH-1:2] < MEM_WORDS);
    assign cfg_hit  = !sram_hit && (i_wb_addr >= OPTN_CFG_ADDR) &&
                      (cfg_ofs[WB_ADDR_WIDTH-1:2] <= CFG_OFS_BEATS);

    assign o_sram_req = '{en: wb_en & sram_hit, we: i_wb_we, eob: wb_eob, burst: wb_burst,
                          sel: i_wb_sel, addr: sram_ofs[WB_ADDR_WIDTH-1:2], data: i_wb_data};
    assign o_cfg_req  = '{en: wb_en & cfg_hit, we: i_wb_we, eob: wb_eob, burst: wb_burst,
                          sel: i_wb_sel, addr: cfg_ofs[WB_ADDR_WIDTH-1:2], data: i_wb_data};

    // Unmapped beat, ack once per beat one cycle later
    always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            unmapped_ack_q <= 1'b0;
        end else begin
            unmapped_ack_q <= wb_en & ~sram_hit & ~cfg_hit & ~unmapped_ack_q;
        end
    end

    // Done straight through to ACK, never outside a pending beat
    assign o_wb_ack = wb_en & (i_sram_rsp.done | i_cfg_rsp.done | unmapped_ack_q);

    // Unmapped reads see zero
    always_comb begin
        if (i_sram_rsp.done) begin
            o_wb_data = i_sram_rsp.data;
        end else if (i_cfg_rsp.done) begin
            o_wb_data = i_cfg_rsp.data;
        end else begin
            o_wb_data = '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/wb_biu_pkg.sv
// Shared Wishbone BIU definitions
// Bus widths, CTI and BTE codes
// Configuration register word offsets
// BIU request, response and steering structs
`default_nettype none

package wb_biu_pkg;

    // Bus widths
    localparam int WB_DATA_WIDTH = 32;
    localparam int WB_ADDR_WIDTH = 32;
    localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;
    // Word address after dropping byte offset bits
    localparam int WB_WORD_WIDTH = WB_ADDR_WIDTH - 2;
    localparam int WB_CTI_WIDTH  = 3;
    localparam int WB_BTE_WIDTH  = 2;

    // Cycle type identifiers
    localparam logic [WB_CTI_WIDTH-1:0] WB_CTI_CLASSIC = 3'b000;
    localparam logic [WB_CTI_WIDTH-1:0] WB_CTI_INCR    = 3'b010;
    localparam logic [WB_CTI_WIDTH-1:0] WB_CTI_EOB     = 3'b111;

    // Linear burst extension, the only one streamed
    localparam logic [WB_BTE_WIDTH-1:0] WB_BTE_LINEAR  = 2'b00;

    // Word offsets inside the configuration window
    localparam logic [WB_WORD_WIDTH-1:0] CFG_OFS_CTRL  = 30'd0;
    localparam logic [WB_WORD_WIDTH-1:0] CFG_OFS_BEATS = 30'd1;

    // One pending beat towards a target
    typedef struct packed {
        logic                     en;
        logic                     we;
        logic                     eob;
        logic                     burst;
        logic [WB_SEL_WIDTH-1:0]  sel;
        logic [WB_WORD_WIDTH-1:0] addr;
        logic [WB_DATA_WIDTH-1:0] data;
    } biu_req_t;

    // Target answer, data valid with done
    typedef struct packed {
        logic                     done;
        logic [WB_DATA_WIDTH-1:0] data;
    } biu_rsp_t;

    // Steering from config block to SRAM controller
    typedef struct packed {
        logic [2:0] wait_states;
        logic       write_protect;
    } cfg_ctrl_t;

endpackage

`default_nettype wire
